/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // One instruction word, viewed as R, I or J format
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm16;
    } i;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target26;
    } j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK
  } wb_sel_t;

  typedef enum logic [2:0] {
    FLOW_SEQ,
    FLOW_BEQ,
    FLOW_BNE,
    FLOW_JUMP,
    FLOW_JR
  } flow_t;

  // Primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_JAL     = 6'h03;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_SLTI    = 6'h0a;
  localparam logic [5:0] OP_ANDI    = 6'h0c;
  localparam logic [5:0] OP_ORI     = 6'h0d;
  localparam logic [5:0] OP_XORI    = 6'h0e;
  localparam logic [5:0] OP_LUI     = 6'h0f;
  localparam logic [5:0] OP_LW      = 6'h23;
  localparam logic [5:0] OP_SW      = 6'h2b;

  // Function codes under OP_SPECIAL
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  localparam word_t    RESET_VECTOR = 32'hbfc0_0000;
  localparam reg_idx_t REG_V0       = 5'd2;
  localparam reg_idx_t REG_RA       = 5'd31;

endpackage

`default_nettype wire

/* hw/mips_decoder.sv */
`default_nettype none

module mips_decoder
  import mips_pkg::*;
(
  input  instr_u  instr,
  input  logic    zero,
  output alu_op_t alu_op,
  output logic    use_imm,
  output logic    sign_ext,
  output logic    reg_dst_rd,
  output logic    link,
  output wb_sel_t wb_sel,
  output logic    reg_write,
  output logic    mem_read,
  output logic    mem_write,
  output flow_t   flow,
  output logic    take
);

  always_comb
  begin
    // Defaults describe a nop
    alu_op     = ALU_ADD;
    use_imm    = 1'b0;
    sign_ext   = 1'b1;
    reg_dst_rd = 1'b0;
    link       = 1'b0;
    wb_sel     = WB_ALU;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    flow       = FLOW_SEQ;

    case (instr.r.opcode)
      OP_SPECIAL:
      begin
        reg_dst_rd = 1'b1;
        reg_write  = 1'b1;
        case (instr.r.funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_JR:
          begin
            reg_write = 1'b0;
            flow      = FLOW_JR;
          end
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
      begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        case (instr.i.opcode)
          OP_SLTI: alu_op = ALU_SLT;
          OP_ANDI: alu_op = ALU_AND;
          OP_ORI:  alu_op = ALU_OR;
          OP_XORI: alu_op = ALU_XOR;
          OP_LUI:  alu_op = ALU_LUI;
          default: alu_op = ALU_ADD;
        endcase
        // Logical immediates are zero extended
        sign_ext = !(instr.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI});
      end
      OP_LW:
      begin
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        wb_sel    = WB_MEM;
        reg_write = 1'b1;
      end
      OP_SW:
      begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      OP_BEQ: flow = FLOW_BEQ;
      OP_BNE: flow = FLOW_BNE;
      OP_J:   flow = FLOW_JUMP;
      OP_JAL:
      begin
        flow      = FLOW_JUMP;
        link      = 1'b1;
        wb_sel    = WB_LINK;
        reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // Redirect request toward the fetch unit
  assign take = (flow == FLOW_BEQ && zero) || (flow == FLOW_BNE && !zero) ||
                flow == FLOW_JUMP || flow == FLOW_JR;

endmodule

`default_nettype wire

/* hw/mips_regfile.sv */
`default_nettype none

module mips_regfile
  import mips_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     write_en,
  input  reg_idx_t write_idx,
  input  word_t    write_data,
  input  reg_idx_t read_idx_a,
  input  reg_idx_t read_idx_b,
  output word_t    read_a,
  output word_t    read_b,
  output word_t    register_v0
);

  word_t regs [32];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int k = 0; k < 32; k++)
      begin
        regs[k] <= '0;
      end
    end
    else if (write_en && write_idx != '0)
    begin
      regs[write_idx] <= write_data;
    end
  end

  // $zero never gets written, so it always reads back as zero
  assign read_a      = regs[read_idx_a];
  assign read_b      = regs[read_idx_b];
  assign register_v0 = regs[REG_V0];

endmodule

`default_nettype wire

/* hw/mips_alu.sv */
`default_nettype none

module mips_alu
  import mips_pkg::*;
(
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       zero
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb
  begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {31'b0, lt_signed};
      ALU_SLTU: result = {31'b0, lt_unsigned};
      // Shifts act on rt, which arrives on b
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  // Branch compare of rs against rt
  assign zero = (a == b);

endmodule

`default_nettype wire

/* hw/mips_fetch.sv */
`default_nettype none

module mips_fetch
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clk_enable,
  input  logic  take,
  input  word_t target,
  output word_t pc
);

  logic  pending;
  word_t target_q;
  word_t pc_next;

  // Redirect lands one instruction after the branch, past the delay slot
  assign pc_next = pending ? target_q : pc + 32'd4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= RESET_VECTOR;
      pending <= 1'b0;
    end
    else if (clk_enable)
    begin
      pc      <= pc_next;
      pending <= take;
    end
  end

  // Target payload
  always_ff @(posedge clk)
  begin
    if (clk_enable && take)
    begin
      target_q <= target;
    end
  end

endmodule

`default_nettype wire

/* hw/mips_cpu_harvard.sv */
`default_nettype none

module mips_cpu_harvard
  import mips_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  instr_u   instr;
  alu_op_t  alu_op;
  wb_sel_t  wb_sel;
  flow_t    flow;
  logic     use_imm;
  logic     sign_ext;
  logic     reg_dst_rd;
  logic     link;
  logic     reg_write;
  logic     mem_read;
  logic     mem_write;
  logic     take;
  logic     zero;
  word_t    pc;
  word_t    pc_plus4;
  word_t    imm_ext;
  word_t    target;
  word_t    read_a;
  word_t    read_b;
  word_t    alu_b;
  word_t    alu_result;
  word_t    write_data;
  reg_idx_t write_idx;

  assign instr         = instr_readdata;
  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;

  mips_decoder decoder_inst (
    .instr(instr), .zero(zero), .alu_op(alu_op), .use_imm(use_imm),
    .sign_ext(sign_ext), .reg_dst_rd(reg_dst_rd), .link(link), .wb_sel(wb_sel),
    .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
    .flow(flow), .take(take)
  );

  assign imm_ext = sign_ext ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                            : {16'h0000, instr.i.imm16};

  // Branch, jump and jr targets
  always_comb
  begin
    case (flow)
      FLOW_JUMP: target = {pc_plus4[31:28], instr.j.target26, 2'b00};
      FLOW_JR:   target = read_a;
      default:   target = pc_plus4 + {imm_ext[29:0], 2'b00};
    endcase
  end

  mips_fetch fetch_inst (
    .clk(clk), .reset(reset), .clk_enable(clk_enable),
    .take(take), .target(target), .pc(pc)
  );

  // jal writes ra, otherwise rd for R-type and rt for I-type
  assign write_idx = link ? REG_RA : (reg_dst_rd ? instr.r.rd : instr.i.rt);

  always_comb
  begin
    case (wb_sel)
      WB_MEM:  write_data = data_readdata;
      WB_LINK: write_data = pc + 32'd8;
      default: write_data = alu_result;
    endcase
  end

  mips_regfile regfile_inst (
    .clk(clk), .reset(reset),
    .write_en(reg_write && active && clk_enable),
    .write_idx(write_idx), .write_data(write_data),
    .read_idx_a(instr.r.rs), .read_idx_b(instr.r.rt),
    .read_a(read_a), .read_b(read_b), .register_v0(register_v0)
  );

  assign alu_b = use_imm ? imm_ext : read_b;

  mips_alu alu_inst (
    .op(alu_op), .a(read_a), .b(alu_b), .shamt(instr.r.shamt),
    .result(alu_result), .zero(zero)
  );

  assign data_address   = alu_result;
  assign data_writedata = read_b;
  assign data_read      = mem_read && active;
  assign data_write     = mem_write && active;

  // Halts after fetching from address 0
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active <= 1'b1;
    end
    else if (clk_enable && pc == '0)
    begin
      active <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verif/mips_tb_clock.sv */
`default_nettype none

module mips_tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

/* verif/mips_cpu_properties.sv */
`default_nettype none

module mips_cpu_properties
  import mips_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  active,
  input word_t instr_address,
  input logic  data_read,
  input logic  data_write
);

  timeunit 1ns;
  timeprecision 100ps;

  // Memory strobes are exclusive
  strobes_exclusive: assert property (@(posedge clk) !(data_read && data_write))
    else $error("data_read and data_write are high in the same cycle");

  // Halt is sticky until the next reset
  halt_sticky: assert property (@(posedge clk) (!active && !reset) |=> (!active || reset))
    else $error("active rose again without a reset");

  fetch_aligned: assert property (@(posedge clk) instr_address[1:0] == 2'b00)
    else $error("instr_address is not word aligned");

  // First fetch after reset comes from the reset vector
  fetch_after_reset: assert property (@(posedge clk) $fell(reset) |-> instr_address == RESET_VECTOR)
    else $error("first fetch after reset is not at the reset vector");

endmodule

`default_nettype wire

/* verif/mips_cpu_tb.sv */
`default_nettype none

module mips_cpu_tb
  import mips_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROM_WORDS = 64;
  // Five programs of well under 100 cycles each, reset and pauses included
  localparam int TIMEOUT_CYCLES = 2000;

  logic  clk;
  logic  reset;
  logic  clk_enable;
  logic  active;
  word_t register_v0;
  word_t instr_address;
  word_t instr_readdata;
  word_t data_address;
  logic  data_write;
  logic  data_read;
  word_t data_writedata;
  word_t data_readdata;

  word_t      rom [ROM_WORDS];
  word_t      ram [256];
  word_t      rom_offset;
  logic [5:0] rom_len;
  int         write_count = 0;
  word_t      last_write_addr = '0;
  int         read_count = 0;
  word_t      last_read_addr = '0;
  int         cycle_count = 0;
  int         seed;
  string      test_name;

  mips_tb_clock clock_inst (.clk(clk));

  mips_cpu_harvard mips_cpu_harvard_inst (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable),
    .instr_address(instr_address), .instr_readdata(instr_readdata),
    .data_address(data_address), .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  bind mips_cpu_harvard mips_cpu_properties properties_inst (
    .clk(clk), .reset(reset), .active(active), .instr_address(instr_address),
    .data_read(data_read), .data_write(data_write)
  );

  // Instruction ROM at the reset vector, anything outside reads as a nop
  assign rom_offset     = instr_address - RESET_VECTOR;
  assign instr_readdata = (rom_offset < 32'(ROM_WORDS * 4)) ? rom[rom_offset[7:2]] : '0;

  assign data_readdata = ram[data_address[9:2]];

  always @(posedge clk)
  begin
    if (data_write && clk_enable)
    begin
      ram[data_address[9:2]] <= data_writedata;
    end
  end

  // Store monitor
  always @(negedge clk)
  begin
    if (data_write && clk_enable && !reset)
    begin
      write_count     <= write_count + 1;
      last_write_addr <= data_address;
    end
  end

  // Load monitor
  always @(negedge clk)
  begin
    if (data_read && clk_enable && !reset)
    begin
      read_count     <= read_count + 1;
      last_read_addr <= data_address;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
  end

  initial
  begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
    $display("Simulation failed");
    $fatal(1, "Run did not finish in time");
  end

  function automatic word_t r_format(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                     logic [4:0] shamt, logic [5:0] funct);
    return {OP_SPECIAL, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t i_format(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_format(logic [5:0] op, logic [25:0] target);
    return {op, target};
  endfunction

  task automatic start_program();
    rom     = '{default: '0};
    rom_len = '0;
  endtask

  task automatic emit(input word_t word);
    rom[rom_len] = word;
    rom_len      = rom_len + 6'd1;
  endtask

  // jr $zero with a nop in its delay slot ends the program at address 0
  task automatic finish_program();
    emit(r_format(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(32'h0000_0000);
  endtask

  task automatic reset_core();
    @(posedge clk);
    reset      <= 1'b1;
    clk_enable <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_to_halt();
    @(negedge clk);
    while (active)
    begin
      @(negedge clk);
    end
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Word check failed");
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Mismatch in %s, %s: expected %b, actual %b", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Bit check failed");
    end
  endtask

  task automatic arithmetic_test();
    word_t       a;
    word_t       b;
    word_t       r;
    logic [15:0] imm;
    word_t       expected;
    test_name = "arithmetic";
    a   = $random(seed);
    b   = $random(seed);
    r   = $random(seed);
    imm = r[15:0];
    start_program();
    emit(i_format(OP_LUI, 5'd0, 5'd8, a[31:16]));
    emit(i_format(OP_ORI, 5'd8, 5'd8, a[15:0]));
    emit(i_format(OP_LUI, 5'd0, 5'd9, b[31:16]));
    emit(i_format(OP_ORI, 5'd9, 5'd9, b[15:0]));
    emit(r_format(5'd8, 5'd9, 5'd10, 5'd0, FN_ADDU));
    emit(r_format(5'd8, 5'd9, 5'd11, 5'd0, FN_SUBU));
    emit(r_format(5'd10, 5'd11, 5'd12, 5'd0, FN_AND));
    emit(r_format(5'd12, 5'd8, 5'd13, 5'd0, FN_XOR));
    emit(r_format(5'd8, 5'd9, 5'd14, 5'd0, FN_SLT));
    emit(r_format(5'd0, 5'd14, 5'd15, 5'd5, FN_SLL));
    emit(i_format(OP_ADDIU, 5'd13, 5'd24, imm));
    emit(r_format(5'd24, 5'd15, REG_V0, 5'd0, FN_ADDU));
    finish_program();
    expected = ((a + b) & (a - b)) ^ a;
    expected = expected + {{16{imm[15]}}, imm};
    // slt result shifted left by 5
    expected = expected + (($signed(a) < $signed(b)) ? 32'd32 : 32'd0);
    reset_core();
    run_to_halt();
    check_bit("active after halt", 1'b0, active);
    check_word("v0", expected, register_v0);
  endtask

  task automatic memory_test();
    word_t value;
    word_t r;
    word_t addr;
    int    writes_before;
    int    reads_before;
    test_name = "memory";
    value = $random(seed);
    r     = $random(seed);
    addr  = {22'd0, r[7:0], 2'b00};
    start_program();
    emit(i_format(OP_LUI, 5'd0, 5'd8, value[31:16]));
    emit(i_format(OP_ORI, 5'd8, 5'd8, value[15:0]));
    emit(i_format(OP_SW, 5'd0, 5'd8, addr[15:0]));
    emit(i_format(OP_LW, 5'd0, REG_V0, addr[15:0]));
    finish_program();
    reset_core();
    writes_before = write_count;
    reads_before  = read_count;
    run_to_halt();
    check_word("ram word", value, ram[addr[9:2]]);
    check_word("v0", value, register_v0);
    check_word("store count", 32'd1, word_t'(write_count - writes_before));
    check_word("store address", addr, last_write_addr);
    check_word("load count", 32'd1, word_t'(read_count - reads_before));
    check_word("load address", addr, last_read_addr);
  endtask

  task automatic delay_slot_test();
    word_t expected;
    test_name = "branch delay slot";
    start_program();
    emit(i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0001));
    emit(i_format(OP_BEQ, 5'd0, 5'd0, 16'd2));
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0010));
    // Skipped by the taken beq
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
    emit(i_format(OP_BNE, 5'd0, 5'd0, 16'd3));
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h1000));
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h2000));
    finish_program();
    expected = 32'h0001 + 32'h0010 + 32'h1000 + 32'h2000;
    reset_core();
    run_to_halt();
    check_bit("active after halt", 1'b0, active);
    check_word("v0", expected, register_v0);
  endtask

  task automatic link_test();
    word_t sub_addr;
    word_t post_addr;
    word_t expected;
    word_t v0_halt;
    word_t ram_halt;
    int    writes_halt;
    test_name = "jal and jr";
    sub_addr  = RESET_VECTOR + 32'h20;
    post_addr = RESET_VECTOR + 32'h2c;
    start_program();
    emit(i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0005));
    emit(j_format(OP_JAL, sub_addr[27:2]));
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0020));
    // Return point at offset 0x0c
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0300));
    emit(i_format(OP_SW, 5'd0, REG_V0, 16'h0080));
    emit(i_format(OP_SW, 5'd0, REG_RA, 16'h0084));
    // Final jr to 0, its delay slot sends the halted core back into the ROM
    emit(r_format(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(j_format(OP_J, post_addr[27:2]));
    // Subroutine
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h4000));
    emit(r_format(REG_RA, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0600));
    // Fetched only after the halt, must not write
    emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'h7000));
    emit(i_format(OP_SW, 5'd0, REG_V0, 16'h0080));
    expected = 32'h0005 + 32'h0020 + 32'h4000 + 32'h0600 + 32'h0300;
    reset_core();
    run_to_halt();
    check_word("v0", expected, register_v0);
    check_word("stored v0", expected, ram[8'h20]);
    check_word("stored ra", RESET_VECTOR + 32'h0c, ram[8'h21]);
    v0_halt     = register_v0;
    ram_halt    = ram[8'h20];
    writes_halt = write_count;
    repeat (20)
    begin
      @(negedge clk);
      check_bit("active after halt", 1'b0, active);
      check_word("v0 after halt", v0_halt, register_v0);
      check_word("ram after halt", ram_halt, ram[8'h20]);
      check_word("stores after halt", word_t'(writes_halt), word_t'(write_count));
    end
  endtask

  task automatic stall_test();
    word_t expected;
    word_t pc_hold;
    word_t v0_hold;
    test_name = "clock enable";
    start_program();
    emit(i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0011));
    expected = 32'h0011;
    for (int k = 1; k <= 6; k++)
    begin
      emit(i_format(OP_ADDIU, REG_V0, REG_V0, 16'(k * 257)));
      expected = expected + 32'(k * 257);
    end
    finish_program();
    reset_core();
    repeat (3) @(posedge clk);
    clk_enable <= 1'b0;
    @(negedge clk);
    pc_hold = instr_address;
    v0_hold = register_v0;
    repeat (14)
    begin
      @(negedge clk);
      check_word("instr_address during pause", pc_hold, instr_address);
      check_word("v0 during pause", v0_hold, register_v0);
    end
    @(posedge clk);
    clk_enable <= 1'b1;
    run_to_halt();
    check_word("v0", expected, register_v0);
  endtask

  initial
  begin
    seed       = 32'hda1c;
    reset      = 1'b1;
    clk_enable = 1'b1;
    test_name  = "startup";
    arithmetic_test();
    memory_test();
    delay_slot_test();
    link_test();
    stall_test();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* mips_cpu.f */
hw/mips_pkg.sv
hw/mips_decoder.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_fetch.sv
hw/mips_cpu_harvard.sv
verif/mips_tb_clock.sv
verif/mips_cpu_properties.sv
verif/mips_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module mips_cpu_tb -f mips_cpu.f \
  && ./obj_dir/Vmips_cpu_tb > sim.log 2>&1 \
  && ! grep -q "Simulation failed" sim.log \
  && echo "Simulation completed successfully" \
  || { echo "Simulation failed"; exit 1; }
